//--- rs.f
rtl/instr_pkg.sv
rtl/rename_pkg.sv
rtl/rs_reg_trk.sv
rtl/rs_entry.sv
rtl/rs_alloc.sv
rtl/rs_issue_select.sv
rtl/rs_top.sv
verification/rs_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator
# The result is taken from the simulation log

rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module rs_tb -f rs.f -o rs_sim \
    && ./obj_dir/rs_sim > sim.log 2>&1

grep -q "^Test OK$" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

//--- verification/rs_tb.sv
module rs_tb;

    localparam int NUM_ENTRIES  = 8;
    localparam int NUM_WRITES   = 2;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 1800;
    localparam int MAX_CYCLES   = 2000;
    // Small register pool so writebacks hit pending sources often
    localparam int PREG_POOL    = 8;

    typedef struct packed {
        instr_pkg::t_opcode          opcode;
        rename_pkg::t_rob_id         robid;
        rename_pkg::t_preg           pdst;
        rename_pkg::t_preg           psrc1;
        rename_pkg::t_preg           psrc2;
        logic                        pend1;
        logic                        pend2;
        logic [instr_pkg::IMM_W-1:0] imm;
    } t_uop;

    logic                        clk;
    logic                        reset;
    logic                        flush;
    logic                        disp_valid;
    logic                        disp_ready;
    instr_pkg::t_opcode          disp_opcode;
    rename_pkg::t_rob_id         disp_robid;
    rename_pkg::t_preg           disp_pdst;
    rename_pkg::t_preg           disp_psrc1;
    logic                        disp_psrc1_pend;
    rename_pkg::t_preg           disp_psrc2;
    logic                        disp_psrc2_pend;
    logic [instr_pkg::IMM_W-1:0] disp_imm;
    logic [NUM_WRITES-1:0]       wb_en;
    rename_pkg::t_preg           wb_preg [NUM_WRITES-1:0];
    logic                        iss_valid;
    logic                        iss_ready;
    instr_pkg::t_opcode          iss_opcode;
    rename_pkg::t_rob_id         iss_robid;
    rename_pkg::t_preg           iss_pdst;
    rename_pkg::t_preg           iss_psrc1;
    rename_pkg::t_preg           iss_psrc2;
    logic [instr_pkg::IMM_W-1:0] iss_imm;

    int                  seed = 32'hf8f9;
    // Micro-ops held by the station, oldest first
    t_uop                model_q [$];
    t_uop                exp_uop;
    int                  exp_idx;
    logic                exp_disp_ready;
    logic                exp_iss_valid;
    logic                flush_prev;
    logic                seen_dispatch;
    rename_pkg::t_rob_id next_robid;
    int                  issued;

    rs_top #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_WRITES  (NUM_WRITES)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .disp_valid      (disp_valid),
        .disp_ready      (disp_ready),
        .disp_opcode     (disp_opcode),
        .disp_robid      (disp_robid),
        .disp_pdst       (disp_pdst),
        .disp_psrc1      (disp_psrc1),
        .disp_psrc1_pend (disp_psrc1_pend),
        .disp_psrc2      (disp_psrc2),
        .disp_psrc2_pend (disp_psrc2_pend),
        .disp_imm        (disp_imm),
        .wb_en           (wb_en),
        .wb_preg         (wb_preg),
        .iss_valid       (iss_valid),
        .iss_ready       (iss_ready),
        .iss_opcode      (iss_opcode),
        .iss_robid       (iss_robid),
        .iss_pdst        (iss_pdst),
        .iss_psrc1       (iss_psrc1),
        .iss_psrc2       (iss_psrc2),
        .iss_imm         (iss_imm)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic bit chance(input int pct);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return (r % 100) < pct;
    endfunction

    function automatic int rand_range(input int n);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic bit wb_hit(input rename_pkg::t_preg r);
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < NUM_WRITES; k++) begin
            if (wb_en[k] && wb_preg[k] == r) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Apply flush, issue, writebacks and dispatch of the last rising edge
    task automatic update_model();
        t_uop u;
        flush_prev = flush;
        if (flush) begin
            model_q.delete();
        end else begin
            if (exp_iss_valid && iss_ready) begin
                model_q.delete(exp_idx);
                issued++;
            end
            foreach (model_q[i]) begin
                u = model_q[i];
                if (wb_hit(u.psrc1)) u.pend1 = 1'b0;
                if (wb_hit(u.psrc2)) u.pend2 = 1'b0;
                model_q[i] = u;
            end
            if (disp_valid && exp_disp_ready) begin
                u.opcode = disp_opcode;
                u.robid  = disp_robid;
                u.pdst   = disp_pdst;
                u.psrc1  = disp_psrc1;
                u.psrc2  = disp_psrc2;
                // Same-cycle writeback already counts at allocation
                u.pend1  = disp_psrc1_pend & ~wb_hit(disp_psrc1);
                u.pend2  = disp_psrc2_pend & ~wb_hit(disp_psrc2);
                u.imm    = disp_imm;
                model_q.push_back(u);
                next_robid    = next_robid + 1'b1;
                seen_dispatch = 1'b1;
            end
        end
    endtask

    task automatic drive_inputs(input int cyc);
        int phase;
        phase = cyc % 400;
        // Full-station phase with back-pressure and a flush near its end
        if (phase < 60) begin
            iss_ready  = 1'b0;
            disp_valid = chance(85);
            flush      = (phase == 55);
        end else begin
            iss_ready  = chance(75);
            disp_valid = chance(65);
            flush      = chance(2);
        end
        disp_opcode     = instr_pkg::t_opcode'(rand_range(7));
        disp_robid      = next_robid;
        disp_pdst       = rename_pkg::t_preg'(rand_range(64));
        disp_psrc1      = rename_pkg::t_preg'(rand_range(PREG_POOL));
        disp_psrc2      = rename_pkg::t_preg'(rand_range(PREG_POOL));
        disp_psrc1_pend = chance(50);
        disp_psrc2_pend = chance(50);
        disp_imm        = $random(seed);
        for (int k = 0; k < NUM_WRITES; k++) begin
            wb_en[k]   = chance(35);
            wb_preg[k] = rename_pkg::t_preg'(rand_range(PREG_POOL));
        end
    endtask

    // Oldest micro-op with both sources produced
    task automatic compute_expected();
        exp_idx = -1;
        exp_uop = '0;
        foreach (model_q[i]) begin
            if (exp_idx < 0 && !model_q[i].pend1 && !model_q[i].pend2) begin
                exp_idx = i;
                exp_uop = model_q[i];
            end
        end
        exp_iss_valid  = !flush && exp_idx >= 0;
        exp_disp_ready = !flush && model_q.size() < NUM_ENTRIES;
    endtask

    disp_ready_check: assert property (@(posedge clk) disable iff (reset)
        disp_ready == exp_disp_ready)
        else stop_with_error($sformatf("mismatch at %0t: disp_ready is %b, expected %b",
            $time, $sampled(disp_ready), exp_disp_ready));

    iss_valid_check: assert property (@(posedge clk) disable iff (reset)
        iss_valid == exp_iss_valid)
        else stop_with_error($sformatf("mismatch at %0t: iss_valid is %b, expected %b",
            $time, $sampled(iss_valid), exp_iss_valid));

    payload_check: assert property (@(posedge clk) disable iff (reset)
        iss_valid |-> (iss_opcode == exp_uop.opcode && iss_robid == exp_uop.robid
            && iss_pdst == exp_uop.pdst && iss_psrc1 == exp_uop.psrc1
            && iss_psrc2 == exp_uop.psrc2 && iss_imm == exp_uop.imm))
        else stop_with_error($sformatf("mismatch at %0t: issued robid %0d, expected robid %0d",
            $time, $sampled(iss_robid), exp_uop.robid));

    after_flush_check: assert property (@(posedge clk) disable iff (reset)
        flush_prev |-> (!iss_valid && (disp_ready || flush)))
        else stop_with_error($sformatf("mismatch at %0t: station not empty after flush",
            $time));

    after_reset_check: assert property (@(posedge clk) disable iff (reset)
        !seen_dispatch |-> (!iss_valid && (disp_ready || flush)))
        else stop_with_error($sformatf("mismatch at %0t: wrong state before first dispatch",
            $time));

    initial begin
        #((MAX_CYCLES + 50) * CLK_PERIOD);
        stop_with_error("timeout: the test did not finish in the expected time");
    end

    initial begin
        reset           = 1'b1;
        flush           = 1'b0;
        disp_valid      = 1'b0;
        disp_opcode     = instr_pkg::OP_ADD;
        disp_robid      = '0;
        disp_pdst       = '0;
        disp_psrc1      = '0;
        disp_psrc1_pend = 1'b0;
        disp_psrc2      = '0;
        disp_psrc2_pend = 1'b0;
        disp_imm        = '0;
        wb_en           = '0;
        wb_preg[0]      = '0;
        wb_preg[1]      = '0;
        iss_ready       = 1'b0;
        flush_prev      = 1'b0;
        seen_dispatch   = 1'b0;
        next_robid      = '0;
        issued          = 0;
        compute_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            @(negedge clk);
            update_model();
            drive_inputs(cyc);
            compute_expected();
        end
        @(negedge clk);
        if (issued == 0) begin
            stop_with_error("no micro-op was issued during the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- rtl/rs_top.sv
module rs_top #(
    parameter int NUM_ENTRIES = 8,
    parameter int NUM_WRITES  = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,

    // Dispatch
    input  logic                          disp_valid,
    output logic                          disp_ready,
    input  instr_pkg::t_opcode            disp_opcode,
    input  rename_pkg::t_rob_id           disp_robid,
    input  rename_pkg::t_preg             disp_pdst,
    input  rename_pkg::t_preg             disp_psrc1,
    input  logic                          disp_psrc1_pend,
    input  rename_pkg::t_preg             disp_psrc2,
    input  logic                          disp_psrc2_pend,
    input  logic [instr_pkg::IMM_W-1:0]   disp_imm,

    // Writeback broadcast
    input  logic [NUM_WRITES-1:0]         wb_en,
    input  rename_pkg::t_preg             wb_preg [NUM_WRITES-1:0],

    // Issue
    output logic                          iss_valid,
    input  logic                          iss_ready,
    output instr_pkg::t_opcode            iss_opcode,
    output rename_pkg::t_rob_id           iss_robid,
    output rename_pkg::t_preg             iss_pdst,
    output rename_pkg::t_preg             iss_psrc1,
    output rename_pkg::t_preg             iss_psrc2,
    output logic [instr_pkg::IMM_W-1:0]   iss_imm
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [NUM_ENTRIES-1:0]        ent_valid;
    logic [NUM_ENTRIES-1:0]        ent_req;
    logic [NUM_ENTRIES-1:0]        alloc_vec;
    logic [NUM_ENTRIES-1:0]        gnt;
    logic [IDX_W-1:0]              sel_idx;

    instr_pkg::t_opcode            ent_opcode [NUM_ENTRIES];
    rename_pkg::t_rob_id           ent_robid  [NUM_ENTRIES];
    rename_pkg::t_preg             ent_pdst   [NUM_ENTRIES];
    rename_pkg::t_preg             ent_psrc1  [NUM_ENTRIES];
    rename_pkg::t_preg             ent_psrc2  [NUM_ENTRIES];
    logic [instr_pkg::IMM_W-1:0]   ent_imm    [NUM_ENTRIES];

    rs_alloc #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_alloc (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .disp_valid (disp_valid),
        .ent_valid  (ent_valid),
        .disp_ready (disp_ready),
        .alloc_vec  (alloc_vec)
    );

    for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_ent
        rs_entry #(
            .NUM_WRITES (NUM_WRITES)
        ) u_entry (
            .clk             (clk),
            .reset           (reset),
            .flush           (flush),
            .alloc           (alloc_vec[e]),
            .gnt             (gnt[e]),
            .disp_opcode     (disp_opcode),
            .disp_robid      (disp_robid),
            .disp_pdst       (disp_pdst),
            .disp_psrc1      (disp_psrc1),
            .disp_psrc1_pend (disp_psrc1_pend),
            .disp_psrc2      (disp_psrc2),
            .disp_psrc2_pend (disp_psrc2_pend),
            .disp_imm        (disp_imm),
            .wb_en           (wb_en),
            .wb_preg         (wb_preg),
            .valid           (ent_valid[e]),
            .req             (ent_req[e]),
            .opcode          (ent_opcode[e]),
            .robid           (ent_robid[e]),
            .pdst            (ent_pdst[e]),
            .psrc1           (ent_psrc1[e]),
            .psrc2           (ent_psrc2[e]),
            .imm             (ent_imm[e])
        );
    end

    rs_issue_select #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_select (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .alloc_vec (alloc_vec),
        .req       (ent_req),
        .iss_ready (iss_ready),
        .iss_valid (iss_valid),
        .gnt       (gnt),
        .sel_idx   (sel_idx)
    );

    // Payload of the oldest ready entry
    assign iss_opcode = ent_opcode[sel_idx];
    assign iss_robid  = ent_robid[sel_idx];
    assign iss_pdst   = ent_pdst[sel_idx];
    assign iss_psrc1  = ent_psrc1[sel_idx];
    assign iss_psrc2  = ent_psrc2[sel_idx];
    assign iss_imm    = ent_imm[sel_idx];

endmodule

//--- rtl/rs_issue_select.sv
module rs_issue_select #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic [NUM_ENTRIES-1:0]         alloc_vec,
    input  logic [NUM_ENTRIES-1:0]         req,
    input  logic                           iss_ready,
    output logic                           iss_valid,
    output logic [NUM_ENTRIES-1:0]         gnt,
    output logic [$clog2(NUM_ENTRIES)-1:0] sel_idx
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // older[i][j] set means entry j was allocated before entry i
    logic [NUM_ENTRIES-1:0] older [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] sel_oh;
    logic                   iss_ok;

    // New entry is younger than everything present
    // Its column is cleared so no other row sees it as older
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                older[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (alloc_vec[i]) begin
                    older[i] <= ~(NUM_ENTRIES'(1) << i);
                end else begin
                    older[i] <= older[i] & ~alloc_vec;
                end
            end
        end
    end

    // A requester wins when no older entry is also requesting
    always_comb begin
        sel_oh = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            sel_oh[i] = req[i] & ~(|(older[i] & req));
        end
    end

    // Index for the payload mux in the top level
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (sel_oh[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    // No issue while the ROB nukes the window
    assign iss_valid = (|req) & ~flush;
    assign iss_ok    = iss_ready & ~flush;
    assign gnt       = sel_oh & {NUM_ENTRIES{iss_ok}};

endmodule

//--- rtl/rs_alloc.sv
module rs_alloc #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   disp_valid,
    input  logic [NUM_ENTRIES-1:0] ent_valid,
    output logic                   disp_ready,
    output logic [NUM_ENTRIES-1:0] alloc_vec
);

    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

    logic [NUM_ENTRIES-1:0] free_oh;
    logic [NUM_ENTRIES-1:0] valid_q;
    logic [NUM_ENTRIES-1:0] freed;
    logic [CNT_W-1:0]       cnt_q;
    logic [CNT_W-1:0]       freed_cnt;
    logic [CNT_W-1:0]       occ;
    logic                   accept;

    // Lowest-index idle entry, one-hot
    always_comb begin
        free_oh = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_oh    = '0;
                free_oh[i] = 1'b1;
            end
        end
    end

    // Entries that left at the last edge, by grant or flush
    assign freed = valid_q & ~ent_valid;

    always_comb begin
        freed_cnt = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            freed_cnt = freed_cnt + CNT_W'(freed[i]);
        end
    end

    // Counter carries allocations forward, departures are taken off a cycle late
    assign occ        = cnt_q - freed_cnt;
    assign disp_ready = ~flush & (occ != CNT_W'(NUM_ENTRIES));
    assign accept     = disp_valid & disp_ready;
    assign alloc_vec  = accept ? free_oh : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q   <= '0;
            valid_q <= '0;
        end else begin
            cnt_q   <= occ + CNT_W'(accept);
            valid_q <= ent_valid;
        end
    end

endmodule

//--- rtl/rs_entry.sv
module rs_entry #(
    parameter int NUM_WRITES = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,

    input  logic                          alloc,
    input  logic                          gnt,

    input  instr_pkg::t_opcode            disp_opcode,
    input  rename_pkg::t_rob_id           disp_robid,
    input  rename_pkg::t_preg             disp_pdst,
    input  rename_pkg::t_preg             disp_psrc1,
    input  logic                          disp_psrc1_pend,
    input  rename_pkg::t_preg             disp_psrc2,
    input  logic                          disp_psrc2_pend,
    input  logic [instr_pkg::IMM_W-1:0]   disp_imm,

    input  logic [NUM_WRITES-1:0]         wb_en,
    input  rename_pkg::t_preg             wb_preg [NUM_WRITES-1:0],

    output logic                          valid,
    output logic                          req,

    output instr_pkg::t_opcode            opcode,
    output rename_pkg::t_rob_id           robid,
    output rename_pkg::t_preg             pdst,
    output rename_pkg::t_preg             psrc1,
    output rename_pkg::t_preg             psrc2,
    output logic [instr_pkg::IMM_W-1:0]   imm
);

    localparam int NUM_SRCS = 2;

    rename_pkg::t_rs_ent_state state;
    rename_pkg::t_rs_ent_state state_nxt;

    logic                  dealloc;
    rename_pkg::t_preg     src_psrc  [NUM_SRCS];
    logic [NUM_SRCS-1:0]   src_pend;
    logic [NUM_SRCS-1:0]   src_ready;

    // Leaves on issue grant or on a ROB nuke
    assign dealloc = gnt | flush;

    always_comb begin
        state_nxt = state;
        case (state)
            rename_pkg::IDLE:  if (alloc && !flush) state_nxt = rename_pkg::VALID;
            rename_pkg::VALID: if (dealloc) state_nxt = rename_pkg::IDLE;
            default:           state_nxt = rename_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rename_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign valid = (state == rename_pkg::VALID);

    // Micro-op fields, loaded once at allocation
    always_ff @(posedge clk) begin
        if (alloc) begin
            opcode <= disp_opcode;
            robid  <= disp_robid;
            pdst   <= disp_pdst;
            psrc1  <= disp_psrc1;
            psrc2  <= disp_psrc2;
            imm    <= disp_imm;
        end
    end

    // Source operand trackers
    assign src_psrc[0] = disp_psrc1;
    assign src_psrc[1] = disp_psrc2;
    assign src_pend    = {disp_psrc2_pend, disp_psrc1_pend};

    for (genvar s = 0; s < NUM_SRCS; s++) begin : g_src_trk
        rs_reg_trk #(
            .NUM_WRITES (NUM_WRITES)
        ) u_reg_trk (
            .clk        (clk),
            .reset      (reset),
            .alloc      (alloc),
            .dealloc    (dealloc),
            .alloc_psrc (src_psrc[s]),
            .alloc_pend (src_pend[s]),
            .wb_en      (wb_en),
            .wb_preg    (wb_preg),
            .ready      (src_ready[s])
        );
    end

    assign req = valid & (&src_ready);

endmodule

//--- rtl/rs_reg_trk.sv
module rs_reg_trk #(
    parameter int NUM_WRITES = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc,
    input  logic              dealloc,
    input  rename_pkg::t_preg alloc_psrc,
    input  logic              alloc_pend,
    input  logic [NUM_WRITES-1:0] wb_en,
    input  rename_pkg::t_preg wb_preg [NUM_WRITES-1:0],
    output logic              ready
);

    rename_pkg::t_preg psrc;
    logic              pend;
    logic              alloc_hit;
    logic              trk_hit;

    // Compare every writeback port against both the incoming source and
    // the one already held
    always_comb begin
        alloc_hit = 1'b0;
        trk_hit   = 1'b0;
        for (int i = 0; i < NUM_WRITES; i++) begin
            if (wb_en[i] && wb_preg[i] == alloc_psrc) begin
                alloc_hit = 1'b1;
            end
            if (wb_en[i] && wb_preg[i] == psrc) begin
                trk_hit = 1'b1;
            end
        end
    end

    // Pending bit, a same-cycle writeback wins over dispatch
    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
        end else if (alloc) begin
            pend <= alloc_pend & ~alloc_hit;
        end else if (dealloc || trk_hit) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            psrc <= alloc_psrc;
        end
    end

    assign ready = ~pend;

endmodule

//--- rtl/rename_pkg.sv
package rename_pkg;

    // Physical register file index
    localparam int PREG_W = 6;

    // Reorder buffer id
    localparam int ROB_ID_W = 5;

    typedef logic [PREG_W-1:0] t_preg;

    typedef logic [ROB_ID_W-1:0] t_rob_id;

    // Reservation station entry state
    // VALID means the entry holds a micro-op that has not issued yet
    typedef enum logic {
        IDLE  = 1'b0,
        VALID = 1'b1
    } t_rs_ent_state;

endpackage

//--- rtl/instr_pkg.sv
package instr_pkg;

    // Width of the immediate carried with every micro-op
    localparam int IMM_W = 32;

    // Integer ALU opcodes
    // The station only stores and forwards these, decoding happens in the
    // execution unit after issue
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6
    } t_opcode;

endpackage
